// File: Makefile
# Verilator build and run of the peripheral subsystem testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module periph_tb -f flist.f
	./obj_dir/Vperiph_tb > $(LOG) 2>&1 || { cat $(LOG); exit 1; }
	cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: flist.f
+incdir+hw
hw/bus_pkg.sv
hw/irq_pkg.sv
hw/apb_decoder.sv
hw/periph_timer.sv
hw/irq_controller.sv
hw/periph_top.sv
testbench/periph_tb.sv

// File: hw/apb_decoder.sv
// ------------------------------------------------------------
//  APB address decoder
//  region select on paddr[15:12], response mux, error on holes
// ------------------------------------------------------------

`timescale 1ns/100ps

`include "periph_config.svh"

module apb_decoder
(
	input  bus_pkg::apb_req_t apb_i,
	output bus_pkg::apb_rsp_t apb_o,
	output bus_pkg::apb_req_t tmr_req_o [`PERIPH_NUM_TIMERS],
	input  bus_pkg::apb_rsp_t tmr_rsp_i [`PERIPH_NUM_TIMERS],
	output bus_pkg::apb_req_t irc_req_o,
	input  bus_pkg::apb_rsp_t irc_rsp_i
);

	localparam logic [3:0] REGION_IRC = 4'hf;

	logic [3:0]                    region;
	logic [`PERIPH_NUM_TIMERS-1:0] tmr_sel;
	logic                          irc_sel;
	logic                          hole_sel;

	assign region = apb_i.paddr[`PERIPH_ADDR_W-1 -: 4];

	// ------------------------------------------------------------
	// region select
	// ------------------------------------------------------------
	always_comb
	begin
		for (int i = 0; i < `PERIPH_NUM_TIMERS; i++)
		begin
			tmr_sel[i] = apb_i.psel && (region == 4'(i));
		end
		irc_sel  = apb_i.psel && (region == REGION_IRC);
		hole_sel = apb_i.psel && !(|tmr_sel) && !irc_sel;
	end

	// same request to all slaves, psel gated per region
	always_comb
	begin
		for (int i = 0; i < `PERIPH_NUM_TIMERS; i++)
		begin
			tmr_req_o[i]      = apb_i;
			tmr_req_o[i].psel = tmr_sel[i];
		end
		irc_req_o      = apb_i;
		irc_req_o.psel = irc_sel;
	end

	// ------------------------------------------------------------
	// response mux
	// ------------------------------------------------------------
	always_comb
	begin
		apb_o = '0;
		if (hole_sel)
		begin
			// unmapped region answers at once with an error
			apb_o.pready  = apb_i.penable;
			apb_o.pslverr = apb_i.penable;
		end
		else if (irc_sel)
		begin
			apb_o = irc_rsp_i;
		end
		else
		begin
			for (int i = 0; i < `PERIPH_NUM_TIMERS; i++)
			begin
				if (tmr_sel[i])
				begin
					apb_o = tmr_rsp_i[i];
				end
			end
		end
	end

	// checked as each access phase opens
	a_one_slave: assert property (
		@(posedge apb_i.penable) $onehot0({tmr_sel, irc_sel})
	);

endmodule

// File: hw/bus_pkg.sv
// ------------------------------------------------------------
//  APB bus types
//  request and response bundles, timer register map
// ------------------------------------------------------------

`include "periph_config.svh"

package bus_pkg;

	// driven by the master, 51 bits
	typedef struct packed {
		logic                        psel;
		logic                        penable;
		logic                        pwrite;
		logic [`PERIPH_ADDR_W-1:0]   paddr;
		logic [`PERIPH_DATA_W-1:0]   pwdata;
	} apb_req_t;

	// driven by each slave, 34 bits
	typedef struct packed {
		logic                        pready;
		logic                        pslverr;
		logic [`PERIPH_DATA_W-1:0]   prdata;
	} apb_rsp_t;

	// timer offsets from paddr[3:2]
	typedef enum logic [1:0] {
		TMR_CTRL    = 2'd0,
		TMR_COMPARE = 2'd1,
		TMR_COUNT   = 2'd2
	} timer_reg_e;

endpackage

// File: hw/irq_controller.sv
// ------------------------------------------------------------
//  interrupt controller
//  latches timer irqs, masks them, fixed priority to one request
// ------------------------------------------------------------

`timescale 1ns/100ps

`include "periph_config.svh"

module irq_controller
(
	input  logic                          clk,
	input  logic                          reset,
	input  bus_pkg::apb_req_t             apb_i,
	output bus_pkg::apb_rsp_t             apb_o,
	input  logic [`PERIPH_NUM_TIMERS-1:0] irq_src_i,
	output logic                          irq_o
);

	irq_pkg::irc_state_e            state_q;
	irq_pkg::irc_status_t           status_q;
	irq_pkg::irc_reg_e              reg_sel;

	logic [`PERIPH_NUM_TIMERS-1:0]  src_q;
	logic [`PERIPH_NUM_TIMERS-1:0]  src_rise;
	logic [`PERIPH_NUM_TIMERS-1:0]  pending_q;
	logic [`PERIPH_NUM_TIMERS-1:0]  enable_q;
	logic [`PERIPH_NUM_TIMERS-1:0]  candidates;
	logic                           pick_valid;
	logic [1:0]                     pick_id;

	logic                           wait_q;
	logic                           acc;
	logic                           done;
	logic                           ack_wr;
	logic                           enable_wr;
	logic [`PERIPH_DATA_W-1:0]      rdata;

	// ------------------------------------------------------------
	// bus side, one wait state per access
	// ------------------------------------------------------------
	assign acc     = apb_i.psel && apb_i.penable;
	assign done    = acc && wait_q;
	assign reg_sel = irq_pkg::irc_reg_e'(apb_i.paddr[3:2]);

	assign enable_wr = done && apb_i.pwrite && (reg_sel == irq_pkg::IRC_ENABLE);
	assign ack_wr    = done && apb_i.pwrite && (reg_sel == irq_pkg::IRC_ACK)
		&& status_q.valid;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			wait_q <= 1'b0;
		else if (acc)
			wait_q <= !wait_q;
		else
			wait_q <= 1'b0;
	end

	// ------------------------------------------------------------
	// pending and mask
	// ------------------------------------------------------------
	assign src_rise   = irq_src_i & ~src_q;
	assign candidates = pending_q & enable_q;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			src_q     <= '0;
			pending_q <= '0;
			enable_q  <= '0;
		end
		else
		begin
			src_q <= irq_src_i;
			for (int i = 0; i < `PERIPH_NUM_TIMERS; i++)
			begin
				if (src_rise[i])
					pending_q[i] <= 1'b1;
				else if (ack_wr && (status_q.id == 2'(i)))
					pending_q[i] <= 1'b0;
			end
			if (enable_wr)
			begin
				enable_q <= apb_i.pwdata[`PERIPH_NUM_TIMERS-1:0];
			end
		end
	end

	// lowest numbered source wins
	always_comb
	begin
		pick_valid = |candidates;
		pick_id    = '0;
		for (int i = `PERIPH_NUM_TIMERS - 1; i >= 0; i--)
		begin
			if (candidates[i])
				pick_id = 2'(i);
		end
	end

	// ------------------------------------------------------------
	// request / acknowledge FSM
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state_q  <= irq_pkg::IRC_IDLE;
			status_q <= '0;
		end
		else
		begin
			case (state_q)
				irq_pkg::IRC_IDLE:
				begin
					if (pick_valid)
					begin
						state_q        <= irq_pkg::IRC_ACTIVE;
						status_q.valid <= 1'b1;
						status_q.id    <= pick_id;
					end
				end
				irq_pkg::IRC_ACTIVE:
				begin
					if (ack_wr)
					begin
						state_q        <= irq_pkg::IRC_IDLE;
						status_q.valid <= 1'b0;
					end
				end
				default:
				begin
					state_q <= irq_pkg::IRC_IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// read data
	// ------------------------------------------------------------
	always_comb
	begin
		rdata = '0;
		case (reg_sel)
			irq_pkg::IRC_PENDING:
				rdata[`PERIPH_NUM_TIMERS-1:0] = pending_q;
			irq_pkg::IRC_ENABLE:
				rdata[`PERIPH_NUM_TIMERS-1:0] = enable_q;
			irq_pkg::IRC_STATUS:
			begin
				rdata[`PERIPH_DATA_W-1] = status_q.valid;
				rdata[1:0]              = status_q.id;
			end
			default:
				rdata = '0;
		endcase
	end

	assign apb_o = '{pready: done, pslverr: 1'b0, prdata: rdata};

	assign irq_o = status_q.valid;

	// latched status must track the FSM
	a_irq_state: assert property (
		@(posedge clk) disable iff (reset) irq_o == (state_q == irq_pkg::IRC_ACTIVE)
	);

endmodule

// File: hw/irq_pkg.sv
// ------------------------------------------------------------
//  interrupt controller types
//  FSM states, register map and latched status
// ------------------------------------------------------------

package irq_pkg;

	typedef enum logic {
		IRC_IDLE   = 1'b0,
		IRC_ACTIVE = 1'b1
	} irc_state_e;

	// controller offsets from paddr[3:2]
	typedef enum logic [1:0] {
		IRC_PENDING = 2'd0,
		IRC_ENABLE  = 2'd1,
		IRC_STATUS  = 2'd2,
		IRC_ACK     = 2'd3
	} irc_reg_e;

	// source currently presented on irq_o
	typedef struct packed {
		logic       valid;
		logic [1:0] id;
	} irc_status_t;

endpackage

// File: hw/periph_config.svh
// ------------------------------------------------------------
//  peripheral subsystem build constants
//  timer count and bus widths shared by RTL and packages
// ------------------------------------------------------------

`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// number of interval timers on the bus
`define PERIPH_NUM_TIMERS 4

// APB address and data widths
`define PERIPH_ADDR_W 16
`define PERIPH_DATA_W 32

// timer counter and compare width
`define TIMER_CNT_W 16

`endif

// File: hw/periph_timer.sv
// ------------------------------------------------------------
//  interval timer
//  counts to the compare value, then wraps and flags an irq
// ------------------------------------------------------------

`timescale 1ns/100ps

`include "periph_config.svh"

module periph_timer
(
	input  logic              clk,
	input  logic              reset,
	input  bus_pkg::apb_req_t apb_i,
	output bus_pkg::apb_rsp_t apb_o,
	output logic              irq_o
);

	logic                        enable_q;
	logic                        pending_q;
	logic [`TIMER_CNT_W-1:0]     compare_q;
	logic [`TIMER_CNT_W-1:0]     count_q;

	bus_pkg::timer_reg_e         reg_sel;
	logic                        wr_en;
	logic                        ctrl_wr;
	logic                        cmp_wr;
	logic                        expire;
	logic [`PERIPH_DATA_W-1:0]   rdata;

	assign reg_sel = bus_pkg::timer_reg_e'(apb_i.paddr[3:2]);

	// zero wait states, every access completes in its first cycle
	assign wr_en   = apb_i.psel && apb_i.penable && apb_i.pwrite;
	assign ctrl_wr = wr_en && (reg_sel == bus_pkg::TMR_CTRL);
	assign cmp_wr  = wr_en && (reg_sel == bus_pkg::TMR_COMPARE);

	assign expire = enable_q && (count_q == compare_q) && !cmp_wr;

	// ------------------------------------------------------------
	// registers
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			enable_q  <= 1'b0;
			pending_q <= 1'b0;
			compare_q <= '0;
			count_q   <= '0;
		end
		else
		begin
			if (ctrl_wr)
			begin
				enable_q <= apb_i.pwdata[0];
			end

			// new compare value restarts the interval
			if (cmp_wr)
			begin
				compare_q <= apb_i.pwdata[`TIMER_CNT_W-1:0];
				count_q   <= '0;
			end
			else if (enable_q)
			begin
				if (count_q == compare_q)
					count_q <= '0;
				else
					count_q <= count_q + 1'b1;
			end

			// write one to clear, a fresh expiry wins
			if (ctrl_wr && apb_i.pwdata[1])
			begin
				pending_q <= 1'b0;
			end
			if (expire)
			begin
				pending_q <= 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// read data
	// ------------------------------------------------------------
	always_comb
	begin
		rdata = '0;
		case (reg_sel)
			bus_pkg::TMR_CTRL:
			begin
				rdata[1:0] = {pending_q, enable_q};
			end
			bus_pkg::TMR_COMPARE:
			begin
				rdata[`TIMER_CNT_W-1:0] = compare_q;
			end
			bus_pkg::TMR_COUNT:
			begin
				rdata[`TIMER_CNT_W-1:0] = count_q;
			end
			default:
			begin
				rdata = '0;
			end
		endcase
	end

	assign apb_o = '{
		pready:  apb_i.psel && apb_i.penable,
		pslverr: 1'b0,
		prdata:  rdata
	};

	assign irq_o = pending_q;

	// compare writes must not strand the counter above the limit
	a_count_bound: assert property (
		@(posedge clk) disable iff (reset) enable_q |-> (count_q <= compare_q)
	);

endmodule

// File: hw/periph_top.sv
// ------------------------------------------------------------
//  peripheral subsystem top
//  APB decoder, timer bank and interrupt controller
// ------------------------------------------------------------

`timescale 1ns/100ps

`include "periph_config.svh"

module periph_top
(
	input  logic              clk,
	input  logic              reset,
	input  bus_pkg::apb_req_t apb_i,
	output bus_pkg::apb_rsp_t apb_o,
	output logic              irq_o
);

	bus_pkg::apb_req_t             tmr_req [`PERIPH_NUM_TIMERS];
	bus_pkg::apb_rsp_t             tmr_rsp [`PERIPH_NUM_TIMERS];
	bus_pkg::apb_req_t             irc_req;
	bus_pkg::apb_rsp_t             irc_rsp;
	logic [`PERIPH_NUM_TIMERS-1:0] tmr_irq;

	// ------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------
	apb_decoder u_decoder
	(
		.apb_i     (apb_i),
		.apb_o     (apb_o),
		.tmr_req_o (tmr_req),
		.tmr_rsp_i (tmr_rsp),
		.irc_req_o (irc_req),
		.irc_rsp_i (irc_rsp)
	);

	// ------------------------------------------------------------
	// timer bank, one per region 0..N-1
	// ------------------------------------------------------------
	for (genvar i = 0; i < `PERIPH_NUM_TIMERS; i++)
	begin : g_timer
		periph_timer u_timer
		(
			.clk   (clk),
			.reset (reset),
			.apb_i (tmr_req[i]),
			.apb_o (tmr_rsp[i]),
			.irq_o (tmr_irq[i])
		);
	end

	// ------------------------------------------------------------
	// interrupt controller in region F
	// ------------------------------------------------------------
	irq_controller u_irc
	(
		.clk       (clk),
		.reset     (reset),
		.apb_i     (irc_req),
		.apb_o     (irc_rsp),
		.irq_src_i (tmr_irq),
		.irq_o     (irq_o)
	);

endmodule

// File: testbench/periph_stimulus.txt
# columns: op addr wdata expect, all hex; a T line starts a named test
# W write, R read, E read expecting pslverr, Q wait wdata cycles for irq_o, N hold irq_o
T register_access
W 0004 0000abcd 00000000
R 0004 00000000 0000abcd
R 0000 00000000 00000000
W 1004 12345678 00000000
R 1004 00000000 00005678
W 2004 0000ffff 00000000
W 2000 00000001 00000000
R 2000 00000000 00000001
W 2000 00000000 00000000
W 2004 0000ffff 00000000
W 2008 00001234 00000000
R 2008 00000000 00000000
R 200c 00000000 00000000
W f004 00000005 00000000
R f004 00000000 00000005
W f004 00000000 00000000
R f00c 00000000 00000000
T unmapped_region
E 5000 00000000 00000000
W 5004 ffffffff 00000000
R 0004 00000000 0000abcd
R 1004 00000000 00005678
R f004 00000000 00000000
T timer_expiry
W 0004 00000014 00000000
W 0000 00000001 00000000
N 0000 00000064 00000000
R 0000 00000000 00000003
W 0000 00000000 00000000
R 0000 00000000 00000002
W 0000 00000002 00000000
R 0000 00000000 00000000
T irq_priority
W 1004 0000000a 00000000
W 3004 0000000a 00000000
W 1000 00000001 00000000
W 3000 00000001 00000000
N 0000 00000028 00000000
W 1000 00000000 00000000
W 3000 00000000 00000000
R f000 00000000 0000000b
W f004 0000000a 00000000
Q 0000 00000014 00000001
R f008 00000000 80000001
W f00c 00000000 00000000
Q 0000 00000014 00000000
Q 0000 00000014 00000001
R f008 00000000 80000003
W f00c 00000000 00000000
Q 0000 00000014 00000000
N 0000 0000001e 00000000
R f000 00000000 00000001
T irq_masking
W 2004 00000005 00000000
W 2000 00000001 00000000
N 0000 0000001e 00000000
R f000 00000000 00000005
W 2000 00000000 00000000
W 2000 00000002 00000000
R 2000 00000000 00000000
W f004 00000004 00000000
Q 0000 00000014 00000001
R f008 00000000 80000002
W f00c 00000000 00000000
Q 0000 00000014 00000000
R f000 00000000 00000001
T wait_states
R f004 00000000 00000004
R 3004 00000000 0000000a
W f004 00000000 00000000
E 7000 00000000 00000000
R f004 00000000 00000000

// File: testbench/periph_tb.sv
// ------------------------------------------------------------
//  testbench for the peripheral subsystem
//  replays the stimulus file over APB and checks responses
// ------------------------------------------------------------

`timescale 1ns/100ps

`include "periph_config.svh"

module periph_tb;

	localparam int CLK_PERIOD  = 40;
	localparam int APB_TIMEOUT = 16;

	logic              clk;
	logic              reset;
	bus_pkg::apb_req_t apb_req;
	bus_pkg::apb_rsp_t apb_rsp;
	logic              irq;

	int    errors;
	int    checks;
	int    tests_run;
	int    tests_failed;
	int    test_errors;
	bit    test_open;
	string test_name;

	periph_top dut
	(
		.clk   (clk),
		.reset (reset),
		.apb_i (apb_req),
		.apb_o (apb_rsp),
		.irq_o (irq)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(CLK_PERIOD/2) clk = ~clk;
		end
	end

	// ------------------------------------------------------------
	// checks and expected values
	// ------------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("ERR %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// regions 0..N-1 are timers, F is the controller
	function automatic logic region_is_hole(input logic [`PERIPH_ADDR_W-1:0] addr);
		logic [3:0] region;
		region = addr[`PERIPH_ADDR_W-1 -: 4];
		return !((32'(region) < `PERIPH_NUM_TIMERS) || (region == 4'hf));
	endfunction

	// ------------------------------------------------------------
	// APB master
	// ------------------------------------------------------------
	task automatic apb_transfer(input logic write, input logic [`PERIPH_ADDR_W-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic slverr);
		int waits;
		bit done;
		waits  = 0;
		done   = 1'b0;
		rdata  = '0;
		slverr = 1'b0;
		@(negedge clk);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge clk);
		apb_req.penable = 1'b1;
		for (int n = 0; n < APB_TIMEOUT; n++)
		begin
			// sample halfway into the low phase, well clear of both edges
			#(CLK_PERIOD/4);
			if (apb_rsp.pready)
			begin
				rdata  = apb_rsp.prdata;
				slverr = apb_rsp.pslverr;
				done   = 1'b1;
				break;
			end
			waits++;
			@(negedge clk);
		end
		@(negedge clk);
		apb_req = '0;
		if (!done)
		begin
			$display("timeout: no pready for the access to address %h", addr);
			errors++;
		end
		else
		begin
			check_value("wait_states", 32'(waits),
				(addr[`PERIPH_ADDR_W-1 -: 4] == 4'hf) ? 32'd1 : 32'd0);
			check_value("pslverr", 32'(slverr), 32'(region_is_hole(addr)));
		end
	endtask

	// ------------------------------------------------------------
	// interrupt line
	// ------------------------------------------------------------
	task automatic wait_irq(input logic level, input logic [31:0] limit);
		bit seen;
		seen = 1'b0;
		for (int n = 0; n <= int'(limit); n++)
		begin
			if (irq === level)
			begin
				seen = 1'b1;
				break;
			end
			@(negedge clk);
		end
		if (!seen)
		begin
			$display("timeout: irq_o did not reach %0d within %0d cycles", level, limit);
			errors++;
		end
	endtask

	task automatic hold_irq(input logic level, input logic [31:0] cycles);
		logic seen_level;
		seen_level = level;
		for (int n = 0; n < int'(cycles); n++)
		begin
			@(negedge clk);
			if (irq !== level)
			begin
				seen_level = irq;
				break;
			end
		end
		check_value("irq_o", 32'(seen_level), 32'(level));
	endtask

	// ------------------------------------------------------------
	// test bookkeeping
	// ------------------------------------------------------------
	task automatic finish_test();
		if (test_open)
		begin
			tests_run++;
			if (errors == test_errors)
			begin
				$display("test %0d %s: ok", tests_run, test_name);
			end
			else
			begin
				tests_failed++;
				$display("test %0d %s: %0d errors", tests_run, test_name, errors - test_errors);
			end
		end
		test_open = 1'b0;
	endtask

	task automatic run_command(input logic [7:0] op, input logic [31:0] addr,
		input logic [31:0] arg, input logic [31:0] exp);
		logic [31:0] rdata;
		logic        slverr;
		case (op)
			"W":
				apb_transfer(1'b1, addr[`PERIPH_ADDR_W-1:0], arg, rdata, slverr);
			"R":
			begin
				apb_transfer(1'b0, addr[`PERIPH_ADDR_W-1:0], '0, rdata, slverr);
				check_value("prdata", rdata, exp);
			end
			"E":
			begin
				apb_transfer(1'b0, addr[`PERIPH_ADDR_W-1:0], '0, rdata, slverr);
				check_value("pslverr", 32'(slverr), 32'd1);
				check_value("prdata", rdata, exp);
			end
			"Q":
				wait_irq(exp[0], arg);
			"N":
				hold_irq(exp[0], arg);
			default:
			begin
				$display("unknown command %s in the stimulus file", op);
				errors++;
			end
		endcase
	endtask

	// ------------------------------------------------------------
	// stimulus file reader
	// ------------------------------------------------------------
	task automatic run_stimulus();
		int          fd;
		int          code;
		string       line;
		logic [7:0]  op;
		logic [31:0] addr;
		logic [31:0] arg;
		logic [31:0] exp;
		fd = $fopen("testbench/periph_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the stimulus file");
			errors++;
			return;
		end
		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			if (code > 0 && line.len() > 1)
			begin
				op = line.getc(0);
				if (op == "T")
				begin
					finish_test();
					code        = $sscanf(line.substr(1, line.len() - 1), "%s", test_name);
					test_errors = errors;
					test_open   = 1'b1;
				end
				else if (op != "#")
				begin
					code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", addr, arg, exp);
					if (code != 3)
					begin
						$display("malformed line in the stimulus file: %s", line);
						errors++;
					end
					else
					begin
						run_command(op, addr, arg, exp);
					end
				end
			end
		end
		$fclose(fd);
		finish_test();
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial
	begin
		reset        = 1'b1;
		apb_req      = '0;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_errors  = 0;
		test_open    = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		run_stimulus();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule
